//--- tb.f
src/sd_host_pkg.sv
src/sd_reg_file.sv
src/sd_cmd_framer.sv
src/sd_cmd_line.sv
src/sd_resp_checker.sv
src/sd_host_top.sv
sim/sd_host_chk.sv
sim/sd_host_tb.sv

//--- Bender.yml
package:
  name: sd_host

sources:
  - src/sd_host_pkg.sv
  - src/sd_reg_file.sv
  - src/sd_cmd_framer.sv
  - src/sd_cmd_line.sv
  - src/sd_resp_checker.sv
  - src/sd_host_top.sv
  - target: simulation
    files:
      - sim/sd_host_chk.sv
      - sim/sd_host_tb.sv

//--- sim/sd_host_tb.sv
`timescale 1ns/1ns
module sd_host_tb import sd_host_pkg::*; ();

	localparam int fault_none = 0;
	localparam int fault_crc = 1;
	localparam int fault_end = 2;
	localparam int fault_index = 3;
	localparam int fault_silent = 4;
	localparam int num_tests = 6;
	localparam int num_regs = 11;
	localparam int wait_limit = 400;

	logic clock;
	logic reset;
	logic [4:0] adr;
	logic wr_en;
	logic rd_en;
	logic [127:0] data_in;
	logic [127:0] data_out;
	logic cmd_out;
	logic cmd_oe;
	logic cmd_in;

	string test_name [num_tests];
	logic [5:0] test_index [num_tests];
	int test_delay [num_tests];
	int test_fault [num_tests];
	logic [4:0] reg_addr [num_regs];
	logic [127:0] reg_mask [num_regs];

	logic [31:0] rand_state = 32'd36239;
	int errors = 0;
	int run_tests = 0;
	int failed_tests = 0;
	int assert_fails;

	sd_host_top u_sd_host_top (
		.clock(clock),
		.reset(reset),
		.adr_i(adr),
		.wr_en_i(wr_en),
		.rd_en_i(rd_en),
		.data_i(data_in),
		.data_o(data_out),
		.cmd_o(cmd_out),
		.cmd_oe_o(cmd_oe),
		.cmd_i(cmd_in)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Remainder of data * x^7 divided by x^7 + x^3 + 1.
	function automatic logic [6:0] crc_by_division(input logic [39:0] data);
		logic [46:0] rem;
		rem = {data, 7'b0};
		for (int i = 46; i >= 7; i--)
		begin
			if (rem[i])
				rem[i -: 8] = rem[i -: 8] ^ 8'h89;
		end
		return rem[6:0];
	endfunction

	task automatic give_up(input string what);
		$display("timeout: %s", what);
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic compare_value(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		if (actual !== expected)
		begin
			$display("mismatch %s: expected %h, actual %h", what, expected, actual);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		run_tests++;
		if (errors == 0)
			$display("test %s: ok", name);
		else
		begin
			$display("test %s: %0d errors", name, errors);
			failed_tests++;
		end
		errors = 0;
	endtask

	task automatic write_reg(input logic [4:0] a, input logic [127:0] d);
		@(posedge clock);
		adr <= a;
		data_in <= d;
		wr_en <= 1'b1;
		@(posedge clock);
		wr_en <= 1'b0;
	endtask

	task automatic read_reg(input logic [4:0] a, output logic [127:0] d);
		@(posedge clock);
		adr <= a;
		rd_en <= 1'b1;
		@(posedge clock);
		rd_en <= 1'b0;
		@(negedge clock);
		d = data_out;
	endtask

	// The card shifts in the token while the host drives the line.
	task automatic capture_token(output logic [47:0] t);
		int n;
		int bits;
		n = 0;
		bits = 0;
		t = '0;
		while (!cmd_oe && n < wait_limit)
		begin
			@(negedge clock);
			n++;
		end
		if (!cmd_oe)
			give_up("no command token appeared on the CMD line");
		else
		begin
			while (cmd_oe && bits < 60)
			begin
				t = {t[46:0], cmd_out};
				bits++;
				@(negedge clock);
			end
			if (bits != 48)
			begin
				$display("CMD output enable lasted %0d cycles instead of 48", bits);
				errors++;
			end
		end
	endtask

	task automatic drive_response(input logic [5:0] idx, input logic [31:0] arg,
		input int delay, input int fault);
		logic [5:0] ridx;
		logic [6:0] crc;
		logic [47:0] resp;
		ridx = (fault == fault_index) ? idx + 6'd1 : idx;
		crc = crc7({2'b00, ridx, arg ^ 32'h5A5A5A5A});
		if (fault == fault_crc)
			crc = ~crc;
		resp = {2'b00, ridx, arg ^ 32'h5A5A5A5A, crc, (fault == fault_end) ? 1'b0 : 1'b1};
		repeat (delay) @(posedge clock);
		for (int i = 47; i >= 0; i--)
		begin
			@(posedge clock);
			cmd_in <= resp[i];
		end
		@(posedge clock);
		cmd_in <= 1'b1; // Line returns to idle.
	endtask

	task automatic wait_idle();
		logic [127:0] v;
		int n;
		n = 0;
		read_reg(adr_present_state, v);
		while (v[ps_cmd_inhibit] && n < wait_limit)
		begin
			read_reg(adr_present_state, v);
			n++;
		end
		if (v[ps_cmd_inhibit])
			give_up("command inhibit never cleared");
	endtask

	task automatic clear_status();
		write_reg(adr_normal_int_status, 128'hFFFF);
		write_reg(adr_error_int_status, 128'hFFFF);
	endtask

	task automatic fill_table();
		test_name[0] = "good_cmd17";
		test_index[0] = 6'd17;
		test_delay[0] = 2;
		test_fault[0] = fault_none;
		test_name[1] = "good_cmd8";
		test_index[1] = 6'd8;
		test_delay[1] = 0;
		test_fault[1] = fault_none;
		test_name[2] = "bad_crc";
		test_index[2] = 6'd13;
		test_delay[2] = 5;
		test_fault[2] = fault_crc;
		test_name[3] = "bad_end_bit";
		test_index[3] = 6'd55;
		test_delay[3] = 1;
		test_fault[3] = fault_end;
		test_name[4] = "wrong_index";
		test_index[4] = 6'd6;
		test_delay[4] = 3;
		test_fault[4] = fault_index;
		test_name[5] = "silent_card";
		test_index[5] = 6'd2;
		test_delay[5] = 0;
		test_fault[5] = fault_silent;
		reg_addr = '{adr_block_size, adr_block_count, adr_argument, adr_transfer_mode,
			adr_timeout_control, adr_software_reset, adr_normal_int_status_en,
			adr_error_int_status_en, adr_normal_int_signal_en, adr_error_int_signal_en,
			adr_command};
		reg_mask = '{128'hFFF, 128'hFFFF, 128'hFFFF_FFFF, 128'hFFFF, 128'hFFFF, 128'h7,
			128'hFFFF, 128'hFFFF, 128'hFFFF, 128'hFFFF, 128'hFFFF};
	endtask

	task automatic check_registers();
		logic [127:0] v;
		logic [127:0] d;
		read_reg(adr_host_version, v);
		compare_value("registers version", 128'h0002, v);
		for (int i = 0; i < num_regs; i++)
		begin
			read_reg(reg_addr[i], v);
			compare_value($sformatf("registers reset %0d", reg_addr[i]), '0, v);
		end
		// The command register is last; writing it would start a command.
		for (int i = 0; i < num_regs - 1; i++)
		begin
			rand_state = xorshift(rand_state);
			d = {4{rand_state}};
			write_reg(reg_addr[i], d);
			read_reg(reg_addr[i], v);
			compare_value($sformatf("registers readback %0d", reg_addr[i]), d & reg_mask[i], v);
		end
		finish_test("registers");
	endtask

	task automatic run_command(input int k);
		logic [31:0] arg;
		logic [39:0] head;
		logic [47:0] tok;
		logic [127:0] v;
		logic [15:0] exp_err;
		logic [15:0] exp_nrm;
		rand_state = xorshift(rand_state);
		arg = rand_state;
		write_reg(adr_timeout_control, (test_fault[k] == fault_silent) ? 128'd20 : 128'd100);
		write_reg(adr_argument, arg);
		write_reg(adr_command, {test_index[k], 8'h00});
		capture_token(tok);
		head = {1'b0, 1'b1, test_index[k], arg};
		compare_value({test_name[k], " token"}, {head, crc_by_division(head), 1'b1}, tok);
		if (test_fault[k] != fault_silent)
			drive_response(test_index[k], arg, test_delay[k], test_fault[k]);
		wait_idle();
		exp_err = '0;
		case (test_fault[k])
			fault_crc: exp_err[err_cmd_crc] = 1'b1;
			fault_end: exp_err[err_cmd_end_bit] = 1'b1;
			fault_index: exp_err[err_cmd_index] = 1'b1;
			fault_silent: exp_err[err_cmd_timeout] = 1'b1;
			default: exp_err = '0;
		endcase
		exp_nrm = (test_fault[k] == fault_none) ? 16'h0001 : 16'h0000;
		read_reg(adr_command, v);
		compare_value({test_name[k], " command"}, {test_index[k], 8'h00}, v);
		read_reg(adr_response, v);
		compare_value({test_name[k], " response"},
			(test_fault[k] == fault_silent) ? 128'd0 : 128'(arg ^ 32'h5A5A5A5A), v);
		read_reg(adr_normal_int_status, v);
		compare_value({test_name[k], " normal status"}, exp_nrm, v);
		read_reg(adr_error_int_status, v);
		compare_value({test_name[k], " error status"}, exp_err, v);
		clear_status();
		read_reg(adr_normal_int_status, v);
		compare_value({test_name[k], " normal cleared"}, '0, v);
		read_reg(adr_error_int_status, v);
		compare_value({test_name[k], " error cleared"}, '0, v);
		finish_test(test_name[k]);
	endtask

	task automatic check_inhibited_write();
		logic [47:0] tok;
		logic [127:0] v;
		int n;
		write_reg(adr_timeout_control, 128'd20);
		write_reg(adr_command, {6'd9, 8'h00});
		capture_token(tok);
		write_reg(adr_command, {6'd10, 8'h00}); // The card stays silent, so inhibit holds.
		read_reg(adr_present_state, v);
		compare_value("inhibited_write inhibit", 128'h1, v);
		wait_idle();
		read_reg(adr_command, v);
		compare_value("inhibited_write command", {6'd10, 8'h00}, v);
		n = 0;
		while (!cmd_oe && n < 60)
		begin
			@(negedge clock);
			n++;
		end
		if (cmd_oe)
		begin
			$display("a command written under inhibit still sent a token");
			errors++;
		end
		clear_status();
		finish_test("inhibited_write");
	endtask

	initial
	begin
		reset = 1'b1;
		adr = '0;
		wr_en = 1'b0;
		rd_en = 1'b0;
		data_in = '0;
		cmd_in = 1'b1;
		fill_table();
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		check_registers();
		for (int k = 0; k < num_tests; k++)
			run_command(k);
		check_inhibited_write();
		assert_fails = u_sd_host_top.u_sd_cmd_line.u_sd_host_chk.failures;
		$display("tests run %0d, tests failed %0d, assertion failures %0d",
			run_tests, failed_tests, assert_fails);
		if (failed_tests == 0 && assert_fails == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- sim/sd_host_chk.sv
`timescale 1ns/1ns
module sd_host_chk (
	input logic clock,
	input logic reset,
	input logic frame_valid_i,
	input logic cmd_line_i,
	input logic cmd_oe_i,
	input logic resp_valid_i,
	input logic timeout_i
);

	int failures = 0;

	// A token occupies the line for exactly one frame length.
	oe_window: assert property (@(posedge clock) disable iff (reset)
		frame_valid_i |=> cmd_oe_i [*48] ##1 !cmd_oe_i)
	else
	begin
		$error("CMD output enable did not span 48 cycles after frame_valid");
		failures++;
	end

	single_end: assert property (@(posedge clock) disable iff (reset)
		!(resp_valid_i && timeout_i))
	else
	begin
		$error("resp_valid and timeout are high together");
		failures++;
	end

	idle_high: assert property (@(posedge clock) disable iff (reset)
		!cmd_oe_i |-> cmd_line_i)
	else
	begin
		$error("CMD output is low while not driven");
		failures++;
	end

endmodule

bind sd_cmd_line sd_host_chk u_sd_host_chk (
	.clock(clock),
	.reset(reset),
	.frame_valid_i(frame_valid_i),
	.cmd_line_i(cmd_o),
	.cmd_oe_i(cmd_oe_o),
	.resp_valid_i(resp_valid_o),
	.timeout_i(timeout_o)
);

//--- src/sd_host_top.sv
`timescale 1ns/1ns
module sd_host_top import sd_host_pkg::*; (
	input logic clock,
	input logic reset,
	input logic [4:0] adr_i,
	input logic wr_en_i,
	input logic rd_en_i,
	input logic [reg_data_width-1:0] data_i,
	output logic [reg_data_width-1:0] data_o,
	output logic cmd_o,
	output logic cmd_oe_o,
	input logic cmd_i
);

	logic issue;
	logic [cmd_index_width-1:0] cmd_index;
	logic [argument_width-1:0] argument;
	logic [field_width-1:0] timeout_value;
	logic frame_valid;
	logic [frame_width-1:0] frame;
	logic resp_valid;
	logic [frame_width-1:0] resp_frame;
	logic resp_timeout;
	logic cmd_done;
	logic [reg_data_width-1:0] response;
	logic [field_width-1:0] error_status;
	logic [field_width-1:0] normal_status;

	sd_reg_file u_sd_reg_file (
		.clock(clock),
		.reset(reset),
		.adr_i(adr_i),
		.wr_en_i(wr_en_i),
		.rd_en_i(rd_en_i),
		.data_i(data_i),
		.cmd_done_i(cmd_done),
		.response_i(response),
		.error_status_i(error_status),
		.normal_status_i(normal_status),
		.data_o(data_o),
		.issue_o(issue),
		.cmd_index_o(cmd_index),
		.argument_o(argument),
		.timeout_o(timeout_value)
	);

	sd_cmd_framer u_sd_cmd_framer (
		.clock(clock),
		.reset(reset),
		.issue_i(issue),
		.cmd_index_i(cmd_index),
		.argument_i(argument),
		.frame_valid_o(frame_valid),
		.frame_o(frame)
	);

	sd_cmd_line u_sd_cmd_line (
		.clock(clock),
		.reset(reset),
		.frame_valid_i(frame_valid),
		.frame_i(frame),
		.timeout_i(timeout_value),
		.cmd_i(cmd_i),
		.cmd_o(cmd_o),
		.cmd_oe_o(cmd_oe_o),
		.resp_valid_o(resp_valid),
		.resp_frame_o(resp_frame),
		.timeout_o(resp_timeout)
	);

	// The framer keeps the sent token, so its index field is stable in flight.
	sd_resp_checker u_sd_resp_checker (
		.clock(clock),
		.reset(reset),
		.resp_valid_i(resp_valid),
		.resp_frame_i(resp_frame),
		.timeout_i(resp_timeout),
		.sent_index_i(frame[frame_width-3 -: cmd_index_width]),
		.cmd_done_o(cmd_done),
		.response_o(response),
		.error_status_o(error_status),
		.normal_status_o(normal_status)
	);

endmodule

//--- src/sd_resp_checker.sv
`timescale 1ns/1ns
module sd_resp_checker import sd_host_pkg::*; (
	input logic clock,
	input logic reset,
	input logic resp_valid_i,
	input logic [frame_width-1:0] resp_frame_i,
	input logic timeout_i,
	input logic [cmd_index_width-1:0] sent_index_i,
	output logic cmd_done_o,
	output logic [reg_data_width-1:0] response_o,
	output logic [field_width-1:0] error_status_o,
	output logic [field_width-1:0] normal_status_o
);

	logic [field_width-1:0] err;
	logic [field_width-1:0] nrm;

	always_comb
	begin
		err = '0;
		if (timeout_i)
			err[err_cmd_timeout] = 1'b1; // A missing response reports nothing else.
		else
		begin
			if (!resp_frame_i[0])
				err[err_cmd_end_bit] = 1'b1;
			if (resp_frame_i[7:1] != crc7(resp_frame_i[frame_width-1:8]))
				err[err_cmd_crc] = 1'b1;
			if (resp_frame_i[frame_width-3 -: cmd_index_width] != sent_index_i)
				err[err_cmd_index] = 1'b1;
		end
	end

	always_comb
	begin
		nrm = '0;
		nrm[nrm_cmd_complete] = (err == '0);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			cmd_done_o <= 1'b0;
		else
			cmd_done_o <= resp_valid_i || timeout_i;
	end

	always_ff @(posedge clock)
	begin
		if (resp_valid_i || timeout_i)
		begin
			error_status_o <= err;
			normal_status_o <= nrm;
			response_o <= timeout_i ? '0 : reg_data_width'(resp_frame_i[39:8]);
		end
	end

endmodule

//--- src/sd_cmd_line.sv
`timescale 1ns/1ns
module sd_cmd_line import sd_host_pkg::*; (
	input logic clock,
	input logic reset,
	input logic frame_valid_i,
	input logic [frame_width-1:0] frame_i,
	input logic [field_width-1:0] timeout_i,
	input logic cmd_i,
	output logic cmd_o,
	output logic cmd_oe_o,
	output logic resp_valid_o,
	output logic [frame_width-1:0] resp_frame_o,
	output logic timeout_o
);

	typedef enum logic [1:0] {
		st_idle,
		st_send,
		st_receive
	} state_t;

	state_t state;
	logic [frame_cnt_width-1:0] bit_cnt;
	logic [frame_width-1:0] shift;
	logic [field_width-1:0] timer;
	logic rx_started;

	assign resp_frame_o = shift;

	// One shift register serves both directions.
	always_ff @(posedge clock)
	begin
		if (state == st_idle && frame_valid_i)
			shift <= {frame_i[frame_width-2:0], 1'b0}; // Bit 47 leaves directly.
		else if (state == st_send)
			shift <= {shift[frame_width-2:0], 1'b0};
		else if (state == st_receive && (rx_started || !cmd_i))
			shift <= {shift[frame_width-2:0], cmd_i};
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= st_idle;
			cmd_o <= 1'b1;
			cmd_oe_o <= 1'b0;
			resp_valid_o <= 1'b0;
			timeout_o <= 1'b0;
			rx_started <= 1'b0;
			bit_cnt <= '0;
			timer <= '0;
		end
		else
		begin
			resp_valid_o <= 1'b0;
			timeout_o <= 1'b0;
			case (state)
				st_idle:
				begin
					if (frame_valid_i)
					begin
						state <= st_send;
						cmd_oe_o <= 1'b1;
						cmd_o <= frame_i[frame_width-1];
						bit_cnt <= frame_cnt_width'(frame_width - 1);
					end
				end
				st_send:
				begin
					if (bit_cnt == 0)
					begin
						state <= st_receive;
						cmd_oe_o <= 1'b0;
						cmd_o <= 1'b1;
						rx_started <= 1'b0;
						timer <= (timeout_i == 0) ? '1 : timeout_i; // Zero means the longest wait.
					end
					else
					begin
						cmd_o <= shift[frame_width-1];
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				st_receive:
				begin
					if (rx_started)
					begin
						if (bit_cnt == 0)
						begin
							resp_valid_o <= 1'b1;
							state <= st_idle;
						end
						else
							bit_cnt <= bit_cnt - 1'b1;
					end
					else if (!cmd_i)
					begin
						rx_started <= 1'b1; // The start bit is bit 47 of the response.
						bit_cnt <= frame_cnt_width'(frame_width - 2);
					end
					else if (timer == 1)
					begin
						timeout_o <= 1'b1;
						state <= st_idle;
					end
					else
						timer <= timer - 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- src/sd_cmd_framer.sv
`timescale 1ns/1ns
module sd_cmd_framer import sd_host_pkg::*; (
	input logic clock,
	input logic reset,
	input logic issue_i,
	input logic [cmd_index_width-1:0] cmd_index_i,
	input logic [argument_width-1:0] argument_i,
	output logic frame_valid_o,
	output logic [frame_width-1:0] frame_o
);

	logic [39:0] head;
	logic [crc_width-1:0] crc;

	// Start bit, transmission bit, index and argument.
	assign head = {1'b0, 1'b1, cmd_index_i, argument_i};
	assign crc = crc7(head);

	always_ff @(posedge clock)
	begin
		if (reset)
			frame_valid_o <= 1'b0;
		else
			frame_valid_o <= issue_i;
	end

	always_ff @(posedge clock)
	begin
		if (issue_i)
			frame_o <= {head, crc, 1'b1}; // End bit closes the token.
	end

endmodule

//--- src/sd_reg_file.sv
`timescale 1ns/1ns
module sd_reg_file import sd_host_pkg::*; (
	input logic clock,
	input logic reset,
	input logic [4:0] adr_i,
	input logic wr_en_i,
	input logic rd_en_i,
	input logic [reg_data_width-1:0] data_i,
	input logic cmd_done_i,
	input logic [reg_data_width-1:0] response_i,
	input logic [field_width-1:0] error_status_i,
	input logic [field_width-1:0] normal_status_i,
	output logic [reg_data_width-1:0] data_o,
	output logic issue_o,
	output logic [cmd_index_width-1:0] cmd_index_o,
	output logic [argument_width-1:0] argument_o,
	output logic [field_width-1:0] timeout_o
);

	logic [blk_size_width-1:0] block_size;
	logic [field_width-1:0] block_count;
	logic [argument_width-1:0] argument;
	logic [field_width-1:0] transfer_mode;
	logic [field_width-1:0] command;
	logic [reg_data_width-1:0] response;
	logic [field_width-1:0] present_state;
	logic [field_width-1:0] timeout_control;
	logic [sw_reset_width-1:0] software_reset;
	logic [field_width-1:0] normal_int_status;
	logic [field_width-1:0] error_int_status;
	logic [field_width-1:0] normal_int_status_en;
	logic [field_width-1:0] error_int_status_en;
	logic [field_width-1:0] normal_int_signal_en;
	logic [field_width-1:0] error_int_signal_en;
	logic cmd_inhibit;
	logic start_cmd;
	logic [field_width-1:0] nrm_clear;
	logic [field_width-1:0] err_clear;

	assign start_cmd = wr_en_i && (adr_i == adr_command) && !cmd_inhibit;

	assign nrm_clear = (wr_en_i && adr_i == adr_normal_int_status) ? data_i[field_width-1:0] : '0;
	assign err_clear = (wr_en_i && adr_i == adr_error_int_status) ? data_i[field_width-1:0] : '0;

	assign cmd_index_o = command[8 +: cmd_index_width]; // Index sits in bits 13:8.
	assign argument_o = argument;
	assign timeout_o = timeout_control;

	always_comb
	begin
		present_state = '0;
		present_state[ps_cmd_inhibit] = cmd_inhibit;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			block_size <= '0;
			block_count <= '0;
			argument <= '0;
			transfer_mode <= '0;
			command <= '0;
			timeout_control <= '0;
			software_reset <= '0;
			normal_int_status_en <= '0;
			error_int_status_en <= '0;
			normal_int_signal_en <= '0;
			error_int_signal_en <= '0;
		end
		else if (wr_en_i)
		begin
			case (adr_i)
				adr_block_size: block_size <= data_i[blk_size_width-1:0];
				adr_block_count: block_count <= data_i[field_width-1:0];
				adr_argument: argument <= data_i[argument_width-1:0];
				adr_transfer_mode: transfer_mode <= data_i[field_width-1:0];
				adr_command: command <= data_i[field_width-1:0]; // Stored even when inhibited.
				adr_timeout_control: timeout_control <= data_i[field_width-1:0];
				adr_software_reset: software_reset <= data_i[sw_reset_width-1:0];
				adr_normal_int_status_en: normal_int_status_en <= data_i[field_width-1:0];
				adr_error_int_status_en: error_int_status_en <= data_i[field_width-1:0];
				adr_normal_int_signal_en: normal_int_signal_en <= data_i[field_width-1:0];
				adr_error_int_signal_en: error_int_signal_en <= data_i[field_width-1:0];
			endcase
		end
	end

	// Status bits are write-1-to-clear; a completion sets new ones.
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			normal_int_status <= '0;
			error_int_status <= '0;
		end
		else
		begin
			normal_int_status <= (normal_int_status & ~nrm_clear) |
				(cmd_done_i ? normal_status_i : '0);
			error_int_status <= (error_int_status & ~err_clear) |
				(cmd_done_i ? error_status_i : '0);
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			response <= '0;
		else if (cmd_done_i)
			response <= response_i;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			issue_o <= 1'b0;
			cmd_inhibit <= 1'b0;
		end
		else
		begin
			issue_o <= start_cmd;
			if (start_cmd)
				cmd_inhibit <= 1'b1;
			else if (cmd_done_i)
				cmd_inhibit <= 1'b0;
		end
	end

	// A write in the same cycle takes priority over the read.
	always_ff @(posedge clock)
	begin
		if (rd_en_i && !wr_en_i)
		begin
			case (adr_i)
				adr_block_size: data_o <= reg_data_width'(block_size);
				adr_block_count: data_o <= reg_data_width'(block_count);
				adr_argument: data_o <= reg_data_width'(argument);
				adr_transfer_mode: data_o <= reg_data_width'(transfer_mode);
				adr_command: data_o <= reg_data_width'(command);
				adr_response: data_o <= response;
				adr_present_state: data_o <= reg_data_width'(present_state);
				adr_timeout_control: data_o <= reg_data_width'(timeout_control);
				adr_software_reset: data_o <= reg_data_width'(software_reset);
				adr_normal_int_status: data_o <= reg_data_width'(normal_int_status);
				adr_error_int_status: data_o <= reg_data_width'(error_int_status);
				adr_normal_int_status_en: data_o <= reg_data_width'(normal_int_status_en);
				adr_error_int_status_en: data_o <= reg_data_width'(error_int_status_en);
				adr_normal_int_signal_en: data_o <= reg_data_width'(normal_int_signal_en);
				adr_error_int_signal_en: data_o <= reg_data_width'(error_int_signal_en);
				adr_host_version: data_o <= reg_data_width'(host_version_value);
				default: data_o <= '0;
			endcase
		end
	end

endmodule

//--- src/sd_host_pkg.sv
package sd_host_pkg;

	localparam logic [4:0] adr_block_size = 5'd0;
	localparam logic [4:0] adr_block_count = 5'd1;
	localparam logic [4:0] adr_argument = 5'd2;
	localparam logic [4:0] adr_transfer_mode = 5'd3;
	localparam logic [4:0] adr_command = 5'd4;
	localparam logic [4:0] adr_response = 5'd5;
	localparam logic [4:0] adr_present_state = 5'd6;
	localparam logic [4:0] adr_timeout_control = 5'd7;
	localparam logic [4:0] adr_software_reset = 5'd8;
	localparam logic [4:0] adr_normal_int_status = 5'd9;
	localparam logic [4:0] adr_error_int_status = 5'd10;
	localparam logic [4:0] adr_normal_int_status_en = 5'd11;
	localparam logic [4:0] adr_error_int_status_en = 5'd12;
	localparam logic [4:0] adr_normal_int_signal_en = 5'd13;
	localparam logic [4:0] adr_error_int_signal_en = 5'd14;
	localparam logic [4:0] adr_host_version = 5'd15;

	localparam int reg_data_width = 128;
	localparam int frame_width = 48;
	localparam int frame_cnt_width = 6; // Enough to count the bits of one token.
	localparam int field_width = 16; // Most registers are 16 bits wide.
	localparam int argument_width = 32;
	localparam int blk_size_width = 12;
	localparam int sw_reset_width = 3;
	localparam int cmd_index_width = 6;
	localparam int crc_width = 7;

	localparam int err_cmd_timeout = 0;
	localparam int err_cmd_crc = 1;
	localparam int err_cmd_end_bit = 2;
	localparam int err_cmd_index = 3;

	localparam int nrm_cmd_complete = 0;

	localparam int ps_cmd_inhibit = 0;

	localparam logic [15:0] host_version_value = 16'h0002;

	// CRC7 over the first 40 bits of a token, polynomial x^7 + x^3 + 1.
	function automatic logic [crc_width-1:0] crc7(input logic [39:0] data);
		logic [crc_width-1:0] crc;
		logic fb;
		crc = '0;
		for (int i = 39; i >= 0; i--)
		begin
			fb = data[i] ^ crc[crc_width-1];
			crc = {crc[crc_width-2:0], 1'b0};
			if (fb)
				crc = crc ^ 7'h09;
		end
		return crc;
	endfunction

endpackage
